// ==== filelist.f ====
hdl/bitmanip_pkg.sv
hdl/zero_counter.sv
hdl/pop_counter.sv
hdl/bitmanip_alu.sv
hdl/req_fifo.sv
hdl/result_stage.sv
hdl/bitmanip_unit.sv
+incdir+testbench
testbench/tb_bitmanip_unit.sv

// ==== hdl/bitmanip_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitmanip_alu (
    input  bitmanip_pkg::bm_op_e          op,
    input  logic [bitmanip_pkg::xlen-1:0] operand,
    output logic [bitmanip_pkg::xlen-1:0] result
);

    import bitmanip_pkg::*;

    logic [xlen-1:0]    reversed;
    logic [xlen-1:0]    zc_value;
    logic [4:0]         zc_count;
    logic               zc_all_zero;
    logic [count_w-1:0] zero_count;
    logic [count_w-1:0] ones_count;

    // ======================================================================
    // Counting
    // ======================================================================

    // Leading zeros of the operand are the trailing zeros of its mirror image.
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            reversed[i] = operand[xlen-1-i];
        end
    end

    assign zc_value = (op == op_clz) ? reversed : operand;

    zero_counter zero_counter_i (
        .value    (zc_value),
        .count    (zc_count),
        .all_zero (zc_all_zero)
    );

    pop_counter pop_counter_i (
        .value (operand),
        .count (ones_count)
    );

    // A zero operand has xlen leading and trailing zeros.
    assign zero_count = zc_all_zero ? count_w'(xlen) : {1'b0, zc_count};

    // ======================================================================
    // Result select
    // ======================================================================

    always_comb begin
        result = '0;
        case (op)
            op_clz, op_ctz: begin
                result = {{(xlen-count_w){1'b0}}, zero_count};
            end
            op_cpop: begin
                result = {{(xlen-count_w){1'b0}}, ones_count};
            end
            op_rev8: begin
                result = {operand[7:0], operand[15:8], operand[23:16], operand[31:24]};
            end
            op_orc_b: begin
                // Any set bit in a byte fills that whole byte with ones.
                for (int b = 0; b < xlen / 8; b++) begin
                    result[8*b +: 8] = {8{|operand[8*b +: 8]}};
                end
            end
            op_sext_b: begin
                result = {{(xlen-8){operand[7]}}, operand[7:0]};
            end
            op_sext_h: begin
                result = {{(xlen-16){operand[15]}}, operand[15:0]};
            end
            op_zext_h: begin
                result = {{(xlen-16){1'b0}}, operand[15:0]};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/bitmanip_pkg.sv ====
`default_nettype none

package bitmanip_pkg;

    // ======================================================================
    // Datapath widths
    // ======================================================================

    // Operand and result width.
    localparam int xlen = 32;

    // Count results need one bit more than log2(xlen) so that 32 fits.
    localparam int count_w = 6;

    // Width of the request tag carried alongside each operation.
    localparam int tag_w = 4;

    // ======================================================================
    // Flow control
    // ======================================================================

    // Request FIFO depth. Upstream starts with this many credits.
    localparam int in_credits = 4;

    // Credits the unit holds toward the consumer after reset.
    localparam int out_credits_init = 2;

    // Width of the downstream credit counter.
    localparam int out_credit_w = 3;

    // ======================================================================
    // Opcodes
    // ======================================================================

    typedef enum logic [2:0] {
        op_clz    = 3'd0,
        op_ctz    = 3'd1,
        op_cpop   = 3'd2,
        op_rev8   = 3'd3,
        op_orc_b  = 3'd4,
        op_sext_b = 3'd5,
        op_sext_h = 3'd6,
        op_zext_h = 3'd7
    } bm_op_e;

endpackage

`default_nettype wire

// ==== hdl/bitmanip_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitmanip_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  bitmanip_pkg::bm_op_e           in_op,
    input  logic [bitmanip_pkg::xlen-1:0]  in_operand,
    input  logic [bitmanip_pkg::tag_w-1:0] in_tag,
    input  logic                           out_credit,
    output logic                           in_credit,
    output logic                           out_valid,
    output logic [bitmanip_pkg::xlen-1:0]  out_result,
    output logic [bitmanip_pkg::tag_w-1:0] out_tag
);

    import bitmanip_pkg::*;

    logic             head_valid;
    bm_op_e           head_op;
    logic [xlen-1:0]  head_operand;
    logic [tag_w-1:0] head_tag;
    logic [xlen-1:0]  alu_result;
    logic             pop;

    req_fifo req_fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_operand   (in_operand),
        .in_tag       (in_tag),
        .pop          (pop),
        .head_valid   (head_valid),
        .head_op      (head_op),
        .head_operand (head_operand),
        .head_tag     (head_tag),
        .in_credit    (in_credit)
    );

    // The ALU works on the FIFO head, so the result is ready in the pop cycle.
    bitmanip_alu bitmanip_alu_i (
        .op      (head_op),
        .operand (head_operand),
        .result  (alu_result)
    );

    result_stage result_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .alu_result (alu_result),
        .head_tag   (head_tag),
        .out_credit (out_credit),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag)
    );

endmodule

`default_nettype wire

// ==== hdl/pop_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pop_counter (
    input  logic [bitmanip_pkg::xlen-1:0]    value,
    output logic [bitmanip_pkg::count_w-1:0] count
);

    // Partial sums, each level one bit wider than the one below it.
    logic [1:0] sum2  [16];
    logic [2:0] sum4  [8];
    logic [3:0] sum8  [4];
    logic [4:0] sum16 [2];

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum2[i] = {1'b0, value[2*i]} + {1'b0, value[2*i+1]};
        end
        for (int i = 0; i < 8; i++) begin
            sum4[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            sum8[i] = {1'b0, sum4[2*i]} + {1'b0, sum4[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            sum16[i] = {1'b0, sum8[2*i]} + {1'b0, sum8[2*i+1]};
        end
    end

    // Final level: two halfword counts of up to 16 each.
    assign count = {1'b0, sum16[0]} + {1'b0, sum16[1]};

endmodule

`default_nettype wire

// ==== hdl/req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  bitmanip_pkg::bm_op_e           in_op,
    input  logic [bitmanip_pkg::xlen-1:0]  in_operand,
    input  logic [bitmanip_pkg::tag_w-1:0] in_tag,
    input  logic                           pop,
    output logic                           head_valid,
    output bitmanip_pkg::bm_op_e           head_op,
    output logic [bitmanip_pkg::xlen-1:0]  head_operand,
    output logic [bitmanip_pkg::tag_w-1:0] head_tag,
    output logic                           in_credit
);

    import bitmanip_pkg::*;

    // Entry storage, written at the write pointer and read at the read pointer.
    bm_op_e           op_mem      [in_credits];
    logic [xlen-1:0]  operand_mem [in_credits];
    logic [tag_w-1:0] tag_mem     [in_credits];

    logic [$clog2(in_credits)-1:0] wr_ptr;
    logic [$clog2(in_credits)-1:0] rd_ptr;
    logic [$clog2(in_credits+1)-1:0] used;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_mem[wr_ptr]      <= in_op;
            operand_mem[wr_ptr] <= in_operand;
            tag_mem[wr_ptr]     <= in_tag;
        end
    end

    // The producer only sends with a credit in hand, so a write never
    // finds the buffer full.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            used      <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (int'(wr_ptr) == in_credits - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == in_credits - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
            // Every freed entry goes back upstream as one credit.
            in_credit <= pop;
        end
    end

    assign head_valid   = (used != '0);
    assign head_op      = op_mem[rd_ptr];
    assign head_operand = operand_mem[rd_ptr];
    assign head_tag     = tag_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           head_valid,
    input  logic [bitmanip_pkg::xlen-1:0]  alu_result,
    input  logic [bitmanip_pkg::tag_w-1:0] head_tag,
    input  logic                           out_credit,
    output logic                           pop,
    output logic                           out_valid,
    output logic [bitmanip_pkg::xlen-1:0]  out_result,
    output logic [bitmanip_pkg::tag_w-1:0] out_tag
);

    import bitmanip_pkg::*;

    logic [out_credit_w-1:0] credit_cnt;

    // ======================================================================
    // Issue decision
    // ======================================================================

    // A credit returned this cycle can be spent right away.
    assign pop = head_valid && ((credit_cnt != '0) || out_credit);

    // ======================================================================
    // Downstream credits
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= out_credit_w'(out_credits_init);
        end else begin
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    // Result and tag of the head entry taken on this pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            out_result <= alu_result;
            out_tag    <= head_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/zero_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module zero_counter (
    input  logic [bitmanip_pkg::xlen-1:0] value,
    output logic [4:0]                    count,
    output logic                          all_zero
);

    // The count is meaningless for a zero input, so the caller checks this flag.
    assign all_zero = ~(|value);

    // The lowest set bit wins. Each pattern fixes the zeros below that bit,
    // so exactly one item can match a non-zero value.
    always_comb begin
        count = 5'd0;
        casez (value)
            32'b????????_????????_????????_???????1: count = 5'd0;
            32'b????????_????????_????????_??????10: count = 5'd1;
            32'b????????_????????_????????_?????100: count = 5'd2;
            32'b????????_????????_????????_????1000: count = 5'd3;
            32'b????????_????????_????????_???10000: count = 5'd4;
            32'b????????_????????_????????_??100000: count = 5'd5;
            32'b????????_????????_????????_?1000000: count = 5'd6;
            32'b????????_????????_????????_10000000: count = 5'd7;
            32'b????????_????????_???????1_00000000: count = 5'd8;
            32'b????????_????????_??????10_00000000: count = 5'd9;
            32'b????????_????????_?????100_00000000: count = 5'd10;
            32'b????????_????????_????1000_00000000: count = 5'd11;
            32'b????????_????????_???10000_00000000: count = 5'd12;
            32'b????????_????????_??100000_00000000: count = 5'd13;
            32'b????????_????????_?1000000_00000000: count = 5'd14;
            32'b????????_????????_10000000_00000000: count = 5'd15;
            32'b????????_???????1_00000000_00000000: count = 5'd16;
            32'b????????_??????10_00000000_00000000: count = 5'd17;
            32'b????????_?????100_00000000_00000000: count = 5'd18;
            32'b????????_????1000_00000000_00000000: count = 5'd19;
            32'b????????_???10000_00000000_00000000: count = 5'd20;
            32'b????????_??100000_00000000_00000000: count = 5'd21;
            32'b????????_?1000000_00000000_00000000: count = 5'd22;
            32'b????????_10000000_00000000_00000000: count = 5'd23;
            32'b???????1_00000000_00000000_00000000: count = 5'd24;
            32'b??????10_00000000_00000000_00000000: count = 5'd25;
            32'b?????100_00000000_00000000_00000000: count = 5'd26;
            32'b????1000_00000000_00000000_00000000: count = 5'd27;
            32'b???10000_00000000_00000000_00000000: count = 5'd28;
            32'b??100000_00000000_00000000_00000000: count = 5'd29;
            32'b?1000000_00000000_00000000_00000000: count = 5'd30;
            32'b10000000_00000000_00000000_00000000: count = 5'd31;
            default:                                 count = 5'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== testbench/bitmanip_ref.svh ====
`ifndef BITMANIP_REF_SVH
`define BITMANIP_REF_SVH

// Expected result of one unary op, worked out bit by bit from the
// instruction definitions.
function automatic logic [xlen-1:0] expected_result(input bm_op_e op,
                                                    input logic [xlen-1:0] x);
    logic [xlen-1:0] r;
    int n;
    int i;
    r = '0;
    n = 0;
    case (op)
        op_clz: begin
            // Walk down from the top bit until the first one.
            i = xlen - 1;
            while (i >= 0 && x[i] == 1'b0) begin
                n++;
                i--;
            end
            r = xlen'(n);
        end
        op_ctz: begin
            i = 0;
            while (i < xlen && x[i] == 1'b0) begin
                n++;
                i++;
            end
            r = xlen'(n);
        end
        op_cpop: begin
            for (int b = 0; b < xlen; b++) begin
                n += int'(x[b]);
            end
            r = xlen'(n);
        end
        op_rev8: begin
            for (int b = 0; b < xlen / 8; b++) begin
                r[8*b +: 8] = x[8*(xlen/8-1-b) +: 8];
            end
        end
        op_orc_b: begin
            for (int b = 0; b < xlen / 8; b++) begin
                r[8*b +: 8] = (x[8*b +: 8] != 8'h00) ? 8'hff : 8'h00;
            end
        end
        op_sext_b: r = xlen'($signed(x[7:0]));
        op_sext_h: r = xlen'($signed(x[15:0]));
        op_zext_h: r = x & 32'h0000_ffff;
        default:   r = '0;
    endcase
    return r;
endfunction

`endif

// ==== testbench/tb_bitmanip_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bitmanip_unit;

    import bitmanip_pkg::*;

    `include "bitmanip_ref.svh"

    localparam int directed_requests = 48;
    localparam int random_requests   = 300;
    localparam int max_requests      = directed_requests + in_credits + out_credits_init
                                       + random_requests;
    localparam int timeout_cycles    = 40 * max_requests + 200;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    bm_op_e           in_op;
    logic [xlen-1:0]  in_operand;
    logic [tag_w-1:0] in_tag;
    logic             out_credit;
    logic             in_credit;
    logic             out_valid;
    logic [xlen-1:0]  out_result;
    logic [tag_w-1:0] out_tag;

    logic [xlen-1:0]  exp_result_q[$];
    logic [tag_w-1:0] exp_tag_q[$];
    logic [tag_w-1:0] next_tag;
    int               prod_credits;
    int               dut_credits;
    int               consumer_buffered;
    int               stall_left;
    int               requests_sent;
    int               results_seen;
    int               in_credit_count;
    int               cycle_count;
    bit               hold_consumer;

    bitmanip_unit bitmanip_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_operand (in_operand),
        .in_tag     (in_tag),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag)
    );

    always #10 clk = ~clk;

    // ======================================================================
    // Reporting
    // ======================================================================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            fail_run("Value check failed.");
        end
    endtask

    // ======================================================================
    // Producer
    // ======================================================================

    // Called on a falling edge; returns on the falling edge after the request.
    task automatic send_request(input bm_op_e op, input logic [xlen-1:0] operand);
        while (prod_credits == 0) @(negedge clk);
        in_valid   = 1'b1;
        in_op      = op;
        in_operand = operand;
        in_tag     = next_tag;
        exp_result_q.push_back(expected_result(op, operand));
        exp_tag_q.push_back(next_tag);
        next_tag++;
        prod_credits--;
        requests_sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Shifted words give the zero counters a spread of short and long runs.
    function automatic logic [xlen-1:0] random_operand();
        logic [xlen-1:0] v;
        v = $urandom;
        case ($urandom_range(0, 3))
            0:       v = v >> $urandom_range(0, xlen - 1);
            1:       v = v << $urandom_range(0, xlen - 1);
            default: v = v;
        endcase
        return v;
    endfunction

    // ======================================================================
    // Consumer and monitor
    // ======================================================================

    // Each drained result frees one slot, which goes back as a credit.
    always @(negedge clk) begin
        out_credit = 1'b0;
        if (rst_n && !hold_consumer) begin
            if (stall_left != 0) begin
                stall_left--;
            end else if ($urandom_range(0, 49) == 0) begin
                stall_left = $urandom_range(10, 40);
            end else if (consumer_buffered != 0 && $urandom_range(0, 3) != 0) begin
                out_credit = 1'b1;
                consumer_buffered--;
            end
        end
    end

    always @(posedge clk) begin
        logic [xlen-1:0]  exp_res;
        logic [tag_w-1:0] exp_tag;
        if (rst_n) begin
            if (in_credit) begin
                prod_credits++;
                in_credit_count++;
            end
            if (out_valid) begin
                if (dut_credits == 0) begin
                    fail_run("The DUT issued a result while holding no output credit.");
                end else if (exp_result_q.size() == 0) begin
                    fail_run("The DUT issued a result that no request asked for.");
                end else begin
                    exp_res = exp_result_q.pop_front();
                    exp_tag = exp_tag_q.pop_front();
                    check_value("out_result", out_result, exp_res);
                    check_value("out_tag", xlen'(out_tag), xlen'(exp_tag));
                    dut_credits--;
                    consumer_buffered++;
                    results_seen++;
                end
            end
            // A credit granted now can only be spent from the next edge on.
            if (out_credit) begin
                dut_credits++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            fail_run("Timeout: the run did not finish within the cycle limit.");
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        logic [xlen-1:0] edge_operands [6];
        int              pulses;
        edge_operands = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000,
                          32'hffff_ffff, 32'h0001_0000, 32'h0000_ff80};
        void'($urandom(50));
        clk               = 1'b0;
        rst_n             = 1'b0;
        in_valid          = 1'b0;
        in_op             = op_clz;
        in_operand        = '0;
        in_tag            = '0;
        out_credit        = 1'b0;
        next_tag          = '0;
        prod_credits      = in_credits;
        dut_credits       = out_credits_init;
        consumer_buffered = 0;
        stall_left        = 0;
        requests_sent     = 0;
        results_seen      = 0;
        in_credit_count   = 0;
        cycle_count       = 0;
        hold_consumer     = 1'b0;

        // Outputs stay quiet through reset and until the first request.
        for (int c = 0; c < 15; c++) begin
            @(negedge clk);
            if (c == 9) begin
                rst_n = 1'b1;
            end
            check_value("out_valid", xlen'(out_valid), '0);
            check_value("in_credit", xlen'(in_credit), '0);
        end

        for (int o = 0; o < 8; o++) begin
            for (int k = 0; k < 6; k++) begin
                send_request(bm_op_e'(o), edge_operands[k]);
                repeat ($urandom_range(0, 2)) @(negedge clk);
            end
        end

        // Withhold output credits until the FIFO fills and upstream runs dry.
        @(posedge clk);
        hold_consumer = 1'b1;
        @(negedge clk);
        for (int c = 0; c < 30; c++) begin
            if (prod_credits != 0) begin
                send_request(op_cpop, $urandom);
            end else begin
                @(negedge clk);
            end
        end
        check_value("producer credits", xlen'(prod_credits), '0);
        pulses = in_credit_count;
        repeat (10) @(negedge clk);
        check_value("in_credit pulses while stalled", xlen'(in_credit_count), xlen'(pulses));
        @(posedge clk);
        hold_consumer = 1'b0;
        @(negedge clk);

        for (int r = 0; r < random_requests; r++) begin
            send_request(bm_op_e'($urandom_range(0, 7)), random_operand());
            if ($urandom_range(0, 2) == 0) begin
                repeat ($urandom_range(1, 4)) @(negedge clk);
            end
        end

        while (results_seen != requests_sent) @(negedge clk);
        repeat (3) @(negedge clk);
        check_value("in_credit pulses", xlen'(in_credit_count), xlen'(requests_sent));
        check_value("producer credits", xlen'(prod_credits), xlen'(in_credits));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
